// ==== source/request_buffer_pkg.sv ====
package request_buffer_pkg;

	// buffer geometry
	localparam int buffer_depth = 64; // bytes per lane
	localparam int col_width = 10; // bytes per read column
	localparam int res_width = col_width - 2; // bytes per result column

	// address widths
	localparam int baddr_bits = $clog2(buffer_depth); // column address
	localparam int caddr_bits = $clog2(col_width); // read bank lane select
	localparam int waddr_bits = $clog2(res_width); // write bank lane select

	// engine opcodes, low two bits of column byte 0
	localparam logic [1:0] op_add = 2'd0;
	localparam logic [1:0] op_sub = 2'd1;
	localparam logic [1:0] op_mul = 2'd2;
	localparam logic [1:0] op_max = 2'd3;

endpackage

// ==== source/read_bank.sv ====
`timescale 1ns/10ps

module read_bank #(
	parameter int bank_width = request_buffer_pkg::col_width
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic [63:0] data_in,
	input logic [request_buffer_pkg::caddr_bits-1:0] write_sel,
	input logic [request_buffer_pkg::baddr_bits-1:0] address,
	output logic [7:0] data_out [bank_width-1:0]
);

	logic [7:0] mem [bank_width][request_buffer_pkg::buffer_depth]; // mem[lane][byte]

	// host word fills eight consecutive bytes of one lane
	always_ff @(posedge clk) begin
		if (wr && (write_sel < bank_width)) begin
			for (int i = 0; i < 8; i++) begin
				mem[write_sel][{address[request_buffer_pkg::baddr_bits-1:3], 3'(i)}] <=
					data_in[8*i +: 8]; // byte 0 in the low bits
			end
		end
	end

	// column read, one byte from every lane
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < bank_width; l++) begin
				data_out[l] <= '0;
			end
		end else begin
			for (int l = 0; l < bank_width; l++) begin
				data_out[l] <= mem[l][address];
			end
		end
	end

endmodule

// ==== source/write_bank.sv ====
`timescale 1ns/10ps

module write_bank #(
	parameter int bank_width = request_buffer_pkg::res_width
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input logic [7:0] data_in [bank_width-1:0],
	input logic [request_buffer_pkg::waddr_bits-1:0] read_sel,
	input logic [request_buffer_pkg::baddr_bits-1:0] address,
	output logic [7:0] data_out
);

	logic [7:0] mem [bank_width][request_buffer_pkg::buffer_depth]; // mem[lane][byte]

	// a result column lands as one byte per lane
	always_ff @(posedge clk) begin
		if (wr) begin
			for (int l = 0; l < bank_width; l++) begin
				mem[l][address] <= data_in[l];
			end
		end
	end

	// host reads back a single byte
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			data_out <= '0;
		end else begin
			data_out <= mem[read_sel][address];
		end
	end

endmodule

// ==== source/fpu_request_buffer.sv ====
`timescale 1ns/10ps

module fpu_request_buffer (
	input logic clk,
	input logic rst_n,
	input logic [request_buffer_pkg::baddr_bits+request_buffer_pkg::caddr_bits-1:0]
		request_write_address,
	input logic [request_buffer_pkg::baddr_bits+request_buffer_pkg::waddr_bits-1:0]
		request_read_address,
	input logic [63:0] request_data_in,
	output logic [7:0] request_data_out,
	input logic wr_en_rd_buffer,
	input logic wr_en_wr_buffer,
	input logic rd_buffer_sel,
	input logic wr_buffer_sel,
	output logic [7:0] read_col [request_buffer_pkg::col_width-1:0],
	input logic [7:0] write_col [request_buffer_pkg::res_width-1:0],
	input logic [request_buffer_pkg::baddr_bits-1:0] read_col_address,
	input logic [request_buffer_pkg::baddr_bits-1:0] write_col_address
);

	localparam int ab = request_buffer_pkg::baddr_bits;
	localparam int cb = request_buffer_pkg::caddr_bits;
	localparam int wb = request_buffer_pkg::waddr_bits;

	logic [7:0] rb0_out [request_buffer_pkg::col_width-1:0];
	logic [7:0] rb1_out [request_buffer_pkg::col_width-1:0];
	logic [7:0] wb0_out;
	logic [7:0] wb1_out;
	logic rb0_wr, rb1_wr, wb0_wr, wb1_wr;
	logic last_rd_buffer_sel; // aligned with the bank read latency
	logic last_wr_buffer_sel;

	// host owns read bank 0 when rd_buffer_sel is high
	assign rb0_wr = wr_en_rd_buffer && rd_buffer_sel;
	assign rb1_wr = wr_en_rd_buffer && !rd_buffer_sel;
	// engine owns write bank 1 when wr_buffer_sel is high
	assign wb0_wr = wr_en_wr_buffer && !wr_buffer_sel;
	assign wb1_wr = wr_en_wr_buffer && wr_buffer_sel;

	read_bank #(.bank_width(request_buffer_pkg::col_width)) rb0 (
		.clk(clk),
		.rst_n(rst_n),
		.wr(rb0_wr),
		.data_in(request_data_in),
		.write_sel(request_write_address[ab+cb-1:ab]),
		.address(rb0_wr ? request_write_address[ab-1:0] : read_col_address),
		.data_out(rb0_out)
	);

	read_bank #(.bank_width(request_buffer_pkg::col_width)) rb1 (
		.clk(clk),
		.rst_n(rst_n),
		.wr(rb1_wr),
		.data_in(request_data_in),
		.write_sel(request_write_address[ab+cb-1:ab]),
		.address(rb1_wr ? request_write_address[ab-1:0] : read_col_address),
		.data_out(rb1_out)
	);

	write_bank #(.bank_width(request_buffer_pkg::res_width)) wb0 (
		.clk(clk),
		.rst_n(rst_n),
		.wr(wb0_wr),
		.data_in(write_col),
		.read_sel(request_read_address[ab+wb-1:ab]),
		.address(wb0_wr ? write_col_address : request_read_address[ab-1:0]),
		.data_out(wb0_out)
	);

	write_bank #(.bank_width(request_buffer_pkg::res_width)) wb1 (
		.clk(clk),
		.rst_n(rst_n),
		.wr(wb1_wr),
		.data_in(write_col),
		.read_sel(request_read_address[ab+wb-1:ab]),
		.address(wb1_wr ? write_col_address : request_read_address[ab-1:0]),
		.data_out(wb1_out)
	);

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			last_rd_buffer_sel <= 1'b0;
			last_wr_buffer_sel <= 1'b0;
		end else begin
			last_rd_buffer_sel <= rd_buffer_sel;
			last_wr_buffer_sel <= wr_buffer_sel;
		end
	end

	always_comb begin
		for (int l = 0; l < request_buffer_pkg::col_width; l++) begin
			read_col[l] = last_rd_buffer_sel ? rb1_out[l] : rb0_out[l]; // engine side
		end
	end

	assign request_data_out = last_wr_buffer_sel ? wb0_out : wb1_out; // host side

endmodule

// ==== source/column_engine.sv ====
`timescale 1ns/10ps

module column_engine (
	input logic clk,
	input logic rst_n,
	input logic col_valid,
	input logic [request_buffer_pkg::baddr_bits-1:0] col_address,
	input logic [7:0] read_col [request_buffer_pkg::col_width-1:0],
	output logic [7:0] write_col [request_buffer_pkg::res_width-1:0],
	output logic [request_buffer_pkg::baddr_bits-1:0] write_col_address,
	output logic write_en
);

	logic [1:0] opcode;
	logic [7:0] scalar;
	logic [7:0] result [request_buffer_pkg::res_width-1:0];

	assign opcode = read_col[0][1:0];
	assign scalar = read_col[1];

	// every result byte wraps modulo 256
	always_comb begin
		for (int i = 0; i < request_buffer_pkg::res_width; i++) begin
			case (opcode)
				request_buffer_pkg::op_add: result[i] = read_col[i+2] + scalar;
				request_buffer_pkg::op_sub: result[i] = read_col[i+2] - scalar;
				request_buffer_pkg::op_mul: result[i] = read_col[i+2] * scalar; // low byte
				default: result[i] = (read_col[i+2] > scalar) ? read_col[i+2] : scalar;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		write_col <= result;
		write_col_address <= col_address;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			write_en <= 1'b0;
		end else begin
			write_en <= col_valid;
		end
	end

endmodule

// ==== source/column_sequencer.sv ====
`timescale 1ns/10ps

module column_sequencer (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [request_buffer_pkg::baddr_bits:0] col_count,
	output logic [request_buffer_pkg::baddr_bits-1:0] read_col_address,
	output logic col_valid,
	output logic [request_buffer_pkg::baddr_bits-1:0] col_address,
	output logic busy,
	output logic done
);

	logic [request_buffer_pkg::baddr_bits:0] count_reg; // columns in this run
	logic [request_buffer_pkg::baddr_bits-1:0] addr;
	logic issue; // address stage
	logic write_stage; // engine output stage
	logic accept;
	logic last_col;
	logic last_write;

	assign accept = start && !busy && (col_count != '0);
	assign last_col = ({1'b0, addr} == count_reg - 1'b1);
	assign last_write = write_stage && !col_valid; // final column leaving the engine

	assign read_col_address = addr;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			count_reg <= '0;
			addr <= '0;
			issue <= 1'b0;
		end else if (accept) begin
			count_reg <= col_count;
			addr <= '0;
			issue <= 1'b1;
		end else if (issue) begin
			if (last_col) begin
				issue <= 1'b0;
			end else begin
				addr <= addr + 1'b1;
			end
		end
	end

	// bank read takes one cycle, so valid and address follow it
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			col_valid <= 1'b0;
			col_address <= '0;
			write_stage <= 1'b0;
		end else begin
			col_valid <= issue;
			col_address <= addr;
			write_stage <= col_valid;
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= busy && last_write;
			if (accept) begin
				busy <= 1'b1;
			end else if (last_write) begin
				busy <= 1'b0; // drops as done rises
			end
		end
	end

endmodule

// ==== source/request_buffer_top.sv ====
`timescale 1ns/10ps

module request_buffer_top (
	input logic clk,
	input logic rst_n,
	input logic req_wr_en,
	input logic [request_buffer_pkg::baddr_bits+request_buffer_pkg::caddr_bits-1:0] req_wr_addr,
	input logic [63:0] req_wr_data,
	input logic rd_buffer_sel,
	input logic wr_buffer_sel,
	input logic start,
	input logic [request_buffer_pkg::baddr_bits:0] col_count,
	output logic busy,
	output logic done,
	input logic [request_buffer_pkg::baddr_bits+request_buffer_pkg::waddr_bits-1:0] req_rd_addr,
	output logic [7:0] req_rd_data
);

	logic [request_buffer_pkg::baddr_bits-1:0] read_col_address;
	logic [request_buffer_pkg::baddr_bits-1:0] col_address;
	logic [request_buffer_pkg::baddr_bits-1:0] write_col_address;
	logic col_valid;
	logic wr_en_wr_buffer;
	logic [7:0] read_col [request_buffer_pkg::col_width-1:0];
	logic [7:0] write_col [request_buffer_pkg::res_width-1:0];

	column_sequencer column_sequencer_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.col_count(col_count),
		.read_col_address(read_col_address),
		.col_valid(col_valid),
		.col_address(col_address),
		.busy(busy),
		.done(done)
	);

	column_engine column_engine_i (
		.clk(clk),
		.rst_n(rst_n),
		.col_valid(col_valid),
		.col_address(col_address),
		.read_col(read_col),
		.write_col(write_col),
		.write_col_address(write_col_address),
		.write_en(wr_en_wr_buffer)
	);

	fpu_request_buffer fpu_request_buffer_i (
		.clk(clk),
		.rst_n(rst_n),
		.request_write_address(req_wr_addr),
		.request_read_address(req_rd_addr),
		.request_data_in(req_wr_data),
		.request_data_out(req_rd_data),
		.wr_en_rd_buffer(req_wr_en),
		.wr_en_wr_buffer(wr_en_wr_buffer),
		.rd_buffer_sel(rd_buffer_sel),
		.wr_buffer_sel(wr_buffer_sel),
		.read_col(read_col),
		.write_col(write_col),
		.read_col_address(read_col_address),
		.write_col_address(write_col_address)
	);

endmodule

// ==== verif/request_buffer_properties.sv ====
`timescale 1ns/10ps

module request_buffer_properties (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done,
	input logic wr_en,
	input logic [request_buffer_pkg::baddr_bits-1:0] read_col_address
);

	localparam int ab = request_buffer_pkg::baddr_bits;

	int failures = 0; // failed assertions so far

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			failures++;
			$error("done stayed high for more than one cycle");
		end

	// a start that lands while busy must not reload the column address
	start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
		start && busy |=> (read_col_address == $past(read_col_address)) ||
			(read_col_address == $past(read_col_address) + ab'(1)))
		else begin
			failures++;
			$error("start while busy restarted the column sequence");
		end

	done_busy_low: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
		else begin
			failures++;
			$error("busy still high while done pulses");
		end

	write_when_busy: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> busy)
		else begin
			failures++;
			$error("result write while the sequencer is idle");
		end

endmodule

bind request_buffer_top request_buffer_properties request_buffer_properties_i (
	.wr_en(wr_en_wr_buffer),
	.*
);

// ==== verif/request_buffer_tb.sv ====
`timescale 1ns/10ps

module request_buffer_tb;

	localparam int depth = request_buffer_pkg::buffer_depth;
	localparam int cw = request_buffer_pkg::col_width;
	localparam int rw = request_buffer_pkg::res_width;
	localparam int ab = request_buffer_pkg::baddr_bits;
	localparam int cb = request_buffer_pkg::caddr_bits;
	localparam int wb = request_buffer_pkg::waddr_bits;

	logic clk;
	logic rst_n;
	logic req_wr_en;
	logic [ab+cb-1:0] req_wr_addr;
	logic [63:0] req_wr_data;
	logic rd_buffer_sel, wr_buffer_sel;
	logic start;
	logic [ab:0] col_count;
	logic busy, done;
	logic [ab+wb-1:0] req_rd_addr;
	logic [7:0] req_rd_data;

	logic [7:0] rd_model [2][cw][depth]; // expected read bank contents
	logic [7:0] wr_model [2][rw][depth];
	bit wr_known [2][depth]; // columns the engine has written
	logic [23:0] exp_q [$]; // {lane, column, byte}
	logic rd_req, rd_req_d;
	int errors = 0;
	int checks = 0;
	int timeouts = 0;

	request_buffer_top request_buffer_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [7:0] calc_result(input logic [1:0] op, input logic [7:0] scalar,
		input logic [7:0] a);
		int r;
		case (op)
			request_buffer_pkg::op_add: r = int'(a) + int'(scalar);
			request_buffer_pkg::op_sub: r = int'(a) - int'(scalar) + 256;
			request_buffer_pkg::op_mul: r = int'(a) * int'(scalar);
			default: r = (a > scalar) ? int'(a) : int'(scalar); // unsigned max
		endcase
		return 8'(r % 256);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic host_write(input int lane, input int addr, input logic [63:0] word);
		req_wr_en = 1'b1;
		req_wr_addr = {cb'(lane), ab'(addr)};
		req_wr_data = word;
		next_cycle();
		req_wr_en = 1'b0;
	endtask

	task automatic fill_half(input bit edge_values);
		int bank;
		logic [63:0] word;
		bank = rd_buffer_sel ? 0 : 1; // host side
		for (int c = 0; c < depth; c++) begin
			rd_model[bank][0][c] = {6'($urandom), 2'(c % 4)}; // every opcode in turn
			rd_model[bank][1][c] = edge_values ? ((c % 8 < 4) ? 8'd0 : 8'd255) : 8'($urandom);
			for (int l = 2; l < cw; l++) begin
				if (edge_values && l % 3 != 2) begin
					rd_model[bank][l][c] = (l % 3 == 0) ? 8'd0 : 8'd255;
				end else begin
					rd_model[bank][l][c] = 8'($urandom);
				end
			end
		end
		for (int l = 0; l < cw; l++) begin
			for (int g = 0; g < depth / 8; g++) begin
				for (int b = 0; b < 8; b++) begin
					word[8*b +: 8] = rd_model[bank][l][8*g + b];
				end
				host_write(l, 8 * g, word);
			end
		end
	endtask

	task automatic start_engine(input int count);
		int src;
		int dst;
		src = rd_buffer_sel ? 1 : 0;
		dst = wr_buffer_sel ? 1 : 0;
		for (int c = 0; c < count; c++) begin
			for (int i = 0; i < rw; i++) begin
				wr_model[dst][i][c] = calc_result(rd_model[src][0][c][1:0],
					rd_model[src][1][c], rd_model[src][i+2][c]);
			end
			wr_known[dst][c] = 1'b1;
		end
		start = 1'b1;
		col_count = count[ab:0];
		next_cycle();
		start = 1'b0;
	endtask

	task automatic wait_done(input int limit);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < limit && !seen; n++) begin
			next_cycle();
			seen = done;
			checks++;
			assert (done === 1'b1 || busy === 1'b1) else begin
				errors++;
				$display("** Error at %0t: busy low before done", $time);
			end
		end
		if (!seen) begin
			timeouts++;
			$display("timeout: no done pulse within %0d cycles at %0t", limit, $time);
			finish_run();
		end
	endtask

	task automatic read_half();
		int bank;
		bank = wr_buffer_sel ? 0 : 1; // host side
		for (int c = 0; c < depth; c++) begin
			for (int l = 0; l < rw && wr_known[bank][c]; l++) begin
				rd_req = 1'b1;
				req_rd_addr = {wb'(l), ab'(c)};
				exp_q.push_back({8'(l), 8'(c), wr_model[bank][l][c]});
				next_cycle();
			end
		end
		rd_req = 1'b0;
		for (int n = 0; n < 4 && exp_q.size() != 0; n++) begin
			next_cycle();
		end
		if (exp_q.size() != 0) begin
			timeouts++;
			$display("timeout: %0d read-back checks never completed at %0t", exp_q.size(), $time);
			finish_run();
		end
	endtask

	task automatic flip_and_read();
		wr_buffer_sel = !wr_buffer_sel; // the half just written goes to the host
		read_half();
	endtask

	task automatic finish_run();
		int prop_fails;
		prop_fails = request_buffer_top_i.request_buffer_properties_i.failures;
		$display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			checks, errors, prop_fails, timeouts);
		if (errors == 0 && prop_fails == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		rd_req_d <= rd_req;
	end

	// read data is registered, so it is settled by the falling edge
	always @(negedge clk) begin
		logic [23:0] entry;
		if (rd_req_d) begin
			entry = exp_q.pop_front();
			checks++;
			assert (req_rd_data === entry[7:0]) else begin
				errors++;
				$display("** Error at %0t: lane %0d column %0d read %h, expected %h",
					$time, entry[23:16], entry[15:8], req_rd_data, entry[7:0]);
			end
		end
	end

	initial begin
		void'($urandom(32'h578ca436));
		rst_n = 1'b0;
		req_wr_en = 1'b0;
		req_wr_addr = '0;
		req_wr_data = '0;
		rd_buffer_sel = 1'b0;
		wr_buffer_sel = 1'b0;
		start = 1'b0;
		col_count = '0;
		req_rd_addr = '0;
		rd_req = 1'b0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		next_cycle();
		checks++;
		assert (busy === 1'b0 && done === 1'b0) else begin
			errors++;
			$display("** Error at %0t: busy or done active after reset", $time);
		end

		// one full run over random columns
		rd_buffer_sel = 1'b1;
		fill_half(1'b0);
		rd_buffer_sel = 1'b0;
		wr_buffer_sel = 1'b1;
		start_engine(depth);
		wait_done(depth + 8);
		flip_and_read();

		// ping-pong where the host refills the idle read half during each run
		start_engine(depth);
		fork
			wait_done(depth + 8);
			fill_half(1'b0);
		join
		flip_and_read();
		rd_buffer_sel = 1'b1;
		start_engine(depth);
		fork
			wait_done(depth + 8);
			fill_half(1'b0);
		join
		flip_and_read();

		// host reads one write half while the engine fills the other
		rd_buffer_sel = 1'b0;
		start_engine(depth);
		fork
			wait_done(depth + 8);
			read_half();
		join
		flip_and_read();

		// scalars and operands at 0 and 255
		rd_buffer_sel = 1'b1;
		fill_half(1'b1);
		rd_buffer_sel = 1'b0;
		start_engine(depth);
		wait_done(depth + 8);
		flip_and_read();

		// single column run leaves columns 1 and up alone
		rd_buffer_sel = 1'b1;
		start_engine(1);
		wait_done(9);
		flip_and_read();

		start_engine(depth);
		next_cycle();
		start = 1'b1; // busy, so this pulse is dropped
		col_count = (ab + 1)'(1);
		next_cycle();
		start = 1'b0;
		wait_done(depth + 8);
		flip_and_read();

		finish_run();
	end

endmodule

// ==== list.f ====
source/request_buffer_pkg.sv
source/read_bank.sv
source/write_bank.sv
source/fpu_request_buffer.sv
source/column_engine.sv
source/column_sequencer.sv
source/request_buffer_top.sv
verif/request_buffer_properties.sv
verif/request_buffer_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= request_buffer_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
SOURCES := $(wildcard source/*.sv verif/*.sv)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
